/* fp_add_settings.svh */
`ifndef FP_ADD_SETTINGS_SVH
`define FP_ADD_SETTINGS_SVH

// Single precision format
`define FP_WIDTH    32
`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_EXP_BIAS 127

// Carry, hidden, fraction, then guard/round/sticky
`define FP_MANT_W   28

// Canonical quiet NaN, no payload
`define FP_QNAN     32'h7fc00000

`endif

/* fp_add_pkg.sv */
`default_nettype none

package fp_add_pkg;

  // Operand class codes
  typedef enum logic [2:0] {
    FP_ZERO      = 3'b000,
    FP_SUBNORMAL = 3'b001,
    FP_INF       = 3'b010,
    FP_NAN       = 3'b011,
    FP_NORMAL    = 3'b100
  } fp_class_e;

  // Requested operation
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } add_op_e;

  // Supported rounding modes
  typedef enum logic {
    RM_RNE = 1'b0,  // Nearest, ties to even
    RM_RTZ = 1'b1   // Truncate
  } round_mode_e;

endpackage

`default_nettype wire

/* fp_classify.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fp_add_settings.svh"

module fp_classify
  import fp_add_pkg::*;
(
  input  logic [`FP_WIDTH-1:0] operand,
  output fp_class_e            op_class
);

  logic [`FP_EXP_W-1:0]  exp_f;
  logic [`FP_FRAC_W-1:0] frac_f;
  logic                  exp_zero;
  logic                  exp_ones;
  logic                  frac_zero;

  assign exp_f  = operand[`FP_WIDTH-2 -: `FP_EXP_W];
  assign frac_f = operand[`FP_FRAC_W-1:0];

  assign exp_zero  = (exp_f == '0);
  assign exp_ones  = (exp_f == '1);
  assign frac_zero = (frac_f == '0);

  always_comb begin
    if (exp_zero) begin
      op_class = frac_zero ? FP_ZERO : FP_SUBNORMAL;
    end else if (exp_ones) begin
      op_class = frac_zero ? FP_INF : FP_NAN;  // Any NaN, quiet or signalling
    end else begin
      op_class = FP_NORMAL;
    end
  end

endmodule

`default_nettype wire

/* fp_preadder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fp_add_settings.svh"

module fp_preadder
  import fp_add_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  logic [`FP_WIDTH-1:0]   a,
  input  logic [`FP_WIDTH-1:0]   b,
  input  add_op_e                op,
  input  fp_class_e              a_class,
  input  fp_class_e              b_class,
  output logic                   al_valid,
  output logic                   big_sign,
  output logic                   eff_sub,
  output logic                   special_hit,
  output logic                   special_invalid,
  output logic [`FP_EXP_W-1:0]   exp_out,
  output logic [`FP_MANT_W-1:0]  big_mant,
  output logic [`FP_MANT_W-1:0]  small_mant,
  output logic [`FP_WIDTH-1:0]   special_result
);

  ////////////////////////////////////////
  // Unpack
  ////////////////////////////////////////
  logic                  a_sign, b_sign;
  logic [`FP_EXP_W-1:0]  a_exp, b_exp;
  logic [`FP_MANT_W-1:0] a_mant, b_mant;
  logic                  a_ge_b;
  logic                  big_sign_c;
  logic [`FP_EXP_W-1:0]  big_exp, small_exp, exp_diff;
  logic [`FP_MANT_W-1:0] big_m, small_m, lost_mask, small_sh;
  logic [4:0]            shift_amt;
  logic                  sticky;
  logic                  hit_c, invalid_c;
  logic [`FP_WIDTH-1:0]  special_c;

  assign a_sign = a[`FP_WIDTH-1];
  assign b_sign = b[`FP_WIDTH-1] ^ (op == OP_SUB);  // Subtract flips b

  // Subnormals and zero sit at exponent 1 with no hidden bit
  assign a_exp  = (a[30:23] == '0) ? 8'd1 : a[30:23];
  assign b_exp  = (b[30:23] == '0) ? 8'd1 : b[30:23];
  assign a_mant = {1'b0, |a[30:23], a[`FP_FRAC_W-1:0], 3'b000};
  assign b_mant = {1'b0, |b[30:23], b[`FP_FRAC_W-1:0], 3'b000};

  ////////////////////////////////////////
  // Order and align
  ////////////////////////////////////////
  assign a_ge_b     = {a_exp, a_mant} >= {b_exp, b_mant};  // Exponent first, then mantissa
  assign big_sign_c = a_ge_b ? a_sign : b_sign;
  assign big_exp    = a_ge_b ? a_exp : b_exp;
  assign small_exp  = a_ge_b ? b_exp : a_exp;
  assign big_m      = a_ge_b ? a_mant : b_mant;
  assign small_m    = a_ge_b ? b_mant : a_mant;

  assign exp_diff  = big_exp - small_exp;
  assign shift_amt = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
  assign lost_mask = (28'd1 << shift_amt) - 28'd1;
  assign sticky    = |(small_m & lost_mask);
  assign small_sh  = small_m >> shift_amt;

  ////////////////////////////////////////
  // Special operands
  ////////////////////////////////////////
  always_comb begin
    hit_c     = 1'b1;
    invalid_c = 1'b0;
    special_c = `FP_QNAN;
    if (a_class == FP_NAN || b_class == FP_NAN) begin
      special_c = `FP_QNAN;
    end else if (a_class == FP_INF && b_class == FP_INF) begin
      invalid_c = (a_sign != b_sign);  // Inf minus inf
      special_c = invalid_c ? `FP_QNAN : a;
    end else if (a_class == FP_INF) begin
      special_c = a;
    end else if (b_class == FP_INF) begin
      special_c = {b_sign, b[`FP_WIDTH-2:0]};
    end else begin
      hit_c = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      al_valid <= 1'b0;
    end else begin
      al_valid <= in_valid;
    end
  end

  // Stage one payload
  always_ff @(posedge clk) begin
    big_sign        <= big_sign_c;
    eff_sub         <= a_sign ^ b_sign;
    exp_out         <= big_exp;
    big_mant        <= big_m;
    small_mant      <= {small_sh[`FP_MANT_W-1:1], small_sh[0] | sticky};
    special_hit     <= hit_c;
    special_invalid <= invalid_c;
    special_result  <= special_c;
  end

  // Subtraction downstream never goes negative
  a_big_first: assert property (@(posedge clk) disable iff (rst)
    al_valid && !special_hit |-> big_mant >= small_mant);

  a_reset_idle: assert property (@(posedge clk) rst |=> !al_valid);

endmodule

`default_nettype wire

/* fp_mant_addnorm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fp_add_settings.svh"

module fp_mant_addnorm
  import fp_add_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  al_valid,
  input  logic                  big_sign,
  input  logic                  eff_sub,
  input  logic                  special_hit,
  input  logic                  special_invalid,
  input  logic [`FP_EXP_W-1:0]  exp_out,
  input  logic [`FP_MANT_W-1:0] big_mant,
  input  logic [`FP_MANT_W-1:0] small_mant,
  input  logic [`FP_WIDTH-1:0]  special_result,
  input  round_mode_e           round_mode,
  output logic                  out_valid,
  output logic                  flag_invalid,
  output logic                  flag_overflow,
  output logic                  flag_underflow,
  output logic                  flag_inexact,
  output logic [`FP_WIDTH-1:0]  result
);

  logic [`FP_MANT_W-1:0] sum, m_carry, m_norm;
  logic [9:0]            e_carry, sh_lim, e_norm, exp_fin;
  logic [4:0]            lz, sh;
  logic                  tiny, inexact, round_up, overflow, res_sign;
  logic [24:0]           rounded;
  logic [22:0]           frac_fin;
  logic [`FP_WIDTH-1:0]  res_next;

  ////////////////////////////////////////
  // Add and normalize
  ////////////////////////////////////////
  assign sum = eff_sub ? big_mant - small_mant : big_mant + small_mant;

  // Carry out folds back with sticky kept
  assign m_carry = sum[27] ? {1'b0, sum[27:2], sum[1] | sum[0]} : sum;
  assign e_carry = {2'b00, exp_out} + {9'd0, sum[27]};

  always_comb begin
    lz = 5'd27;  // All zero
    for (int i = 0; i < 27; i++) begin
      if (m_carry[i]) begin
        lz = 5'(26 - i);
      end
    end
  end

  // Left shift stops at exponent 1, giving a subnormal
  assign sh_lim = e_carry - 10'd1;
  assign sh     = ({5'd0, lz} > sh_lim) ? sh_lim[4:0] : lz;
  assign m_norm = m_carry << sh;
  assign e_norm = e_carry - {5'd0, sh};

  ////////////////////////////////////////
  // Round and pack
  ////////////////////////////////////////
  assign tiny     = ~m_norm[26];  // Tininess before rounding
  assign inexact  = |m_norm[2:0];
  assign round_up = (round_mode == RM_RNE) && m_norm[2] &&
                    (m_norm[1] | m_norm[0] | m_norm[3]);
  assign rounded  = {1'b0, m_norm[26:3]} + {24'd0, round_up};

  // Rounding carry bumps exponent; subnormal to normal lands on 1
  assign exp_fin  = rounded[24] ? e_norm + 10'd1 : (rounded[23] ? e_norm : 10'd0);
  assign frac_fin = rounded[24] ? rounded[23:1] : rounded[22:0];
  assign overflow = exp_fin > 10'(2 * `FP_EXP_BIAS);
  assign res_sign = (sum == '0 && eff_sub) ? 1'b0 : big_sign;  // Exact cancel gives +0

  always_comb begin
    if (special_hit) begin
      res_next = special_result;
    end else if (overflow) begin
      res_next = (round_mode == RM_RNE) ? {res_sign, 8'hff, 23'd0}
                                        : {res_sign, 8'hfe, {23{1'b1}}};
    end else begin
      res_next = {res_sign, exp_fin[7:0], frac_fin};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid      <= 1'b0;
      flag_invalid   <= 1'b0;
      flag_overflow  <= 1'b0;
      flag_underflow <= 1'b0;
      flag_inexact   <= 1'b0;
    end else begin
      out_valid      <= al_valid;
      flag_invalid   <= al_valid & special_hit & special_invalid;
      flag_overflow  <= al_valid & ~special_hit & overflow;
      flag_underflow <= al_valid & ~special_hit & tiny & inexact;
      flag_inexact   <= al_valid & ~special_hit & (inexact | overflow);
    end
  end

  always_ff @(posedge clk) begin
    result <= res_next;
  end

  a_one_cycle: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(al_valid));

endmodule

`default_nettype wire

/* fp_status_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_status_regs
  import fp_add_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        mode_we,
  input  logic        status_clr,
  input  logic        out_valid,
  input  logic        flag_invalid,
  input  logic        flag_overflow,
  input  logic        flag_underflow,
  input  logic        flag_inexact,
  input  round_mode_e mode_wdata,
  output round_mode_e round_mode,
  output logic [3:0]  status_flags  // Invalid, overflow, underflow, inexact
);

  logic [3:0] new_flags;

  assign new_flags = {flag_invalid, flag_overflow, flag_underflow, flag_inexact};

  always_ff @(posedge clk) begin
    if (rst) begin
      round_mode   <= RM_RNE;
      status_flags <= 4'd0;
    end else begin
      if (mode_we) begin
        round_mode <= mode_wdata;
      end
      if (status_clr) begin
        status_flags <= 4'd0;  // Clear beats a same-cycle flag
      end else if (out_valid) begin
        status_flags <= status_flags | new_flags;
      end
    end
  end

endmodule

`default_nettype wire

/* fp_adder_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fp_add_settings.svh"

module fp_adder_top
  import fp_add_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  logic                 mode_we,
  input  logic                 status_clr,
  input  logic [`FP_WIDTH-1:0] a,
  input  logic [`FP_WIDTH-1:0] b,
  input  add_op_e              op,
  input  round_mode_e          mode_wdata,
  output logic                 out_valid,
  output logic [`FP_WIDTH-1:0] result,
  output logic [3:0]           status_flags
);

  fp_class_e             a_class, b_class;
  logic                  al_valid, big_sign, eff_sub, special_hit, special_invalid;
  logic [`FP_EXP_W-1:0]  exp_out;
  logic [`FP_MANT_W-1:0] big_mant, small_mant;
  logic [`FP_WIDTH-1:0]  special_result;
  round_mode_e           round_mode;
  logic                  flag_invalid, flag_overflow, flag_underflow, flag_inexact;

  fp_classify fp_classify_a_inst (.operand(a), .op_class(a_class));
  fp_classify fp_classify_b_inst (.operand(b), .op_class(b_class));

  // Stage one
  fp_preadder fp_preadder_inst (
    .clk, .rst, .in_valid, .a, .b, .op, .a_class, .b_class,
    .al_valid, .big_sign, .eff_sub, .special_hit, .special_invalid,
    .exp_out, .big_mant, .small_mant, .special_result
  );

  // Stage two
  fp_mant_addnorm fp_mant_addnorm_inst (
    .clk, .rst, .al_valid, .big_sign, .eff_sub, .special_hit, .special_invalid,
    .exp_out, .big_mant, .small_mant, .special_result, .round_mode,
    .out_valid, .flag_invalid, .flag_overflow, .flag_underflow, .flag_inexact,
    .result
  );

  fp_status_regs fp_status_regs_inst (
    .clk, .rst, .mode_we, .status_clr, .out_valid,
    .flag_invalid, .flag_overflow, .flag_underflow, .flag_inexact,
    .mode_wdata, .round_mode, .status_flags
  );

endmodule

`default_nettype wire

/* tb_fp_ref.svh */
`ifndef TB_FP_REF_SVH
`define TB_FP_REF_SVH

// Expected result of x op y, with the flags on top
// Bits 35:32 are invalid, overflow, underflow, inexact
function automatic logic [35:0] fp_add_ref(input logic [31:0] x, input logic [31:0] y,
                                           input add_op_e opr, input round_mode_e rm);
  logic         sx, sy, sr, up;
  logic [287:0] mx, my, mag, rem, half;
  logic [24:0]  keep;
  int           ex, ey, p, sh, e;
  sx = x[31];
  sy = y[31] ^ (opr == OP_SUB);
  if ((x[30:23] == 8'hff && x[22:0] != 23'd0) || (y[30:23] == 8'hff && y[22:0] != 23'd0)) begin
    return {4'b0000, `FP_QNAN};
  end
  if (x[30:23] == 8'hff && y[30:23] == 8'hff) begin
    return (sx != sy) ? {4'b1000, `FP_QNAN} : {4'b0000, x};
  end
  if (x[30:23] == 8'hff) begin
    return {4'b0000, x};
  end
  if (y[30:23] == 8'hff) begin
    return {4'b0000, sy, y[30:0]};
  end

  // Both operands as exact integers in units of 2^-149
  ex = (x[30:23] == 8'd0) ? 0 : int'(x[30:23]) - 1;
  ey = (y[30:23] == 8'd0) ? 0 : int'(y[30:23]) - 1;
  mx = {264'd0, x[30:23] != 8'd0, x[22:0]} << ex;
  my = {264'd0, y[30:23] != 8'd0, y[22:0]} << ey;
  if (sx == sy) begin
    mag = mx + my;
    sr  = sx;
  end else if (mx >= my) begin
    mag = mx - my;
    sr  = (mx == my) ? 1'b0 : sx;  // Exact cancel gives +0
  end else begin
    mag = my - mx;
    sr  = sy;
  end

  p = -1;
  for (int i = 0; i < 288; i++) begin
    if (mag[i]) begin
      p = i;
    end
  end
  // Below 2^24 units the sum fits as is, so never inexact
  if (p < 24) begin
    return {4'b0000, sr, 8'(p == 23), mag[22:0]};
  end

  sh   = p - 23;
  keep = 25'(mag >> sh);
  rem  = mag & ((288'd1 << sh) - 288'd1);
  half = 288'd1 << (sh - 1);
  up   = (rm == RM_RNE) && (rem > half || (rem == half && keep[0]));
  keep = keep + 25'(up);
  e    = sh + 1;
  if (keep[24]) begin
    keep = keep >> 1;  // Rounding carried into a new binade
    e    = e + 1;
  end
  if (e >= 255) begin
    return (rm == RM_RNE) ? {4'b0101, sr, 8'hff, 23'd0} : {4'b0101, sr, 8'hfe, 23'h7fffff};
  end
  return {3'b000, rem != 288'd0, sr, 8'(e), keep[22:0]};
endfunction

`endif

/* tb_fp_adder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fp_add_settings.svh"

module tb_fp_adder
  import fp_add_pkg::*;
();

  localparam int unsigned SEED = 32'hb582_6f1b;
  localparam int N_RAND = 200;
  localparam int DRAIN_LIMIT = 40;  // Cycles

  logic        clk, rst, in_valid, mode_we, status_clr, out_valid;
  logic [31:0] a, b, result;
  logic [3:0]  status_flags;
  add_op_e     op;
  round_mode_e mode_wdata, cur_mode;

  logic [35:0] exp_q[$];
  logic [64:0] opnd_q[$];  // {op, a, b}
  int          cyc_q[$];
  logic [3:0]  exp_sticky;
  int          errors, timeouts, cycle;

  `include "tb_fp_ref.svh"

  fp_adder_top fp_adder_top_inst (
    .clk, .rst, .in_valid, .mode_we, .status_clr, .a, .b, .op, .mode_wdata,
    .out_valid, .result, .status_flags
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////
  always @(posedge clk) begin
    logic [35:0] exp_v;
    logic [64:0] opnd;
    int          c0;
    cycle = cycle + 1;
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR @%0t: out_valid with no operation in flight", $time);
      end else begin
        exp_v = exp_q.pop_front();
        opnd  = opnd_q.pop_front();
        c0    = cyc_q.pop_front();
        assert (result === exp_v[31:0]) else begin
          errors++;
          $display("ERROR @%0t: a=%h b=%h op=%0d expected %h, got %h",
                   $time, opnd[63:32], opnd[31:0], opnd[64], exp_v[31:0], result);
        end
        assert (cycle - c0 == 2) else begin
          errors++;
          $display("ERROR @%0t: out_valid %0d cycles after strobe", $time, cycle - c0);
        end
        exp_sticky = exp_sticky | exp_v[35:32];
      end
    end
    if (!rst && in_valid) begin
      exp_q.push_back(fp_add_ref(a, b, op, cur_mode));
      opnd_q.push_back({op, a, b});
      cyc_q.push_back(cycle);
    end
  end

  function automatic logic [31:0] rand_fp(input int center, input int spread);
    int e;
    e = center + int'($urandom_range(2 * spread)) - spread;
    if (e < 1) e = 1;
    if (e > 254) e = 254;
    return {1'($urandom), 8'(e), 23'($urandom)};
  endfunction

  task automatic issue(input logic [31:0] x, input logic [31:0] y, input add_op_e o);
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= x;
    b        <= y;
    op       <= o;
  endtask

  // Stop issuing, wait for the results, then check the sticky flags
  task automatic drain();
    int t;
    t = 0;
    @(posedge clk);
    in_valid <= 1'b0;
    do begin
      @(negedge clk);
      t++;
    end while (exp_q.size() != 0 && t < DRAIN_LIMIT);
    assert (exp_q.size() == 0) else begin
      timeouts++;
      $display("Timeout: %0d results still missing after %0d cycles", exp_q.size(), t);
    end
    assert (status_flags === exp_sticky) else begin
      errors++;
      $display("ERROR @%0t: status_flags %b, expected %b", $time, status_flags, exp_sticky);
    end
  endtask

  task automatic set_mode(input round_mode_e m);
    @(posedge clk);
    mode_we    <= 1'b1;
    mode_wdata <= m;
    cur_mode = m;
    @(posedge clk);
    mode_we <= 1'b0;
  endtask

  task automatic clear_status();
    @(posedge clk);
    status_clr <= 1'b1;
    @(posedge clk);
    status_clr <= 1'b0;
    exp_sticky = 4'd0;
    @(negedge clk);
    assert (status_flags === 4'd0) else begin
      errors++;
      $display("ERROR @%0t: status_flags %b after clear", $time, status_flags);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [31:0] x;
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    mode_we    = 1'b0;
    status_clr = 1'b0;
    a          = 32'd0;
    b          = 32'd0;
    op         = OP_ADD;
    mode_wdata = RM_RNE;
    cur_mode   = RM_RNE;
    exp_sticky = 4'd0;
    errors     = 0;
    timeouts   = 0;
    cycle      = 0;
    void'($urandom(SEED));

    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      if (i == 3) rst <= 1'b0;  // Held for 4 edges
      @(negedge clk);
      assert (out_valid === 1'b0 && status_flags === 4'd0) else begin
        errors++;
        $display("ERROR @%0t: outputs not idle around reset", $time);
      end
    end

    // Back to back, nearby exponents so rounding matters
    for (int i = 0; i < N_RAND; i++) begin
      x = rand_fp(127, 126);
      issue(x, rand_fp(int'(x[30:23]), 28), add_op_e'(1'($urandom)));
    end
    drain();

    // Cancellation and subnormals
    clear_status();
    for (int i = 0; i < 40; i++) begin
      x = rand_fp(20, 19);
      issue(x, x ^ $urandom_range(255), OP_SUB);
      issue({1'($urandom), 8'd0, 23'($urandom)}, {1'($urandom), 8'd0, 23'($urandom)},
            add_op_e'(1'($urandom)));
      issue({1'($urandom), 8'd0, 23'($urandom)}, rand_fp(2, 1), add_op_e'(1'($urandom)));
      issue(x, x, OP_SUB);
    end
    issue(32'h80000000, 32'h00000000, OP_ADD);
    issue(32'h80000000, 32'h00000000, OP_SUB);
    drain();

    // NaN, infinity, inf minus inf
    clear_status();
    issue(32'h7fc00000, 32'h3f800000, OP_ADD);
    issue(32'h40000000, 32'hff812345, OP_SUB);  // Signalling NaN in b
    issue(32'h7f800000, 32'h3f800000, OP_ADD);
    issue(32'hc2c80000, 32'h7f800000, OP_SUB);
    issue(32'h7f800000, 32'h7f800000, OP_SUB);
    issue(32'hff800000, 32'h7f800000, OP_ADD);
    drain();
    assert (status_flags[3] === 1'b1) else begin
      errors++;
      $display("ERROR @%0t: invalid status bit not set after inf - inf", $time);
    end

    set_mode(RM_RTZ);
    clear_status();
    for (int i = 0; i < 100; i++) begin
      x = rand_fp(127, 126);
      issue(x, rand_fp(int'(x[30:23]), 28), add_op_e'(1'($urandom)));
    end
    issue(32'h7f7fffff, 32'h7f7fffff, OP_ADD);  // Saturates at max finite
    drain();
    set_mode(RM_RNE);

    // Sticky accumulation: overflow, then a tie to even
    clear_status();
    issue(32'h7f7fffff, 32'h7f7fffff, OP_ADD);
    issue(32'h3f800000, 32'h33800000, OP_ADD);
    drain();
    clear_status();

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
fp_add_pkg.sv
fp_classify.sv
fp_preadder.sv
fp_mant_addnorm.sv
fp_status_regs.sv
fp_adder_top.sv
tb_fp_adder.sv

/* Makefile */
# Verilator simulation of the floating-point adder

VERILATOR ?= verilator
TOP       ?= tb_fp_adder
FLIST     ?= list.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/10ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(MDIR)
